//--- hw/ste_glue_pkg.sv
// ------------------------------
// shared constants, enums and structs of the STE glue logic
// referenced by scoped name from every RTL block
// ------------------------------

package ste_glue_pkg;

	// chipset register page, high address byte
	localparam logic [7:0] IO_PAGE = 8'hff;

	// blitter window, 64 bytes from here
	localparam logic [15:0] BLITTER_BASE = 16'h8a00;

	// dma windows inside the io page
	localparam logic [15:0] DMA_WIN_A = 16'h8608;   // 4 bytes
	localparam logic [15:0] DMA_WIN_B = 16'h860c;   // 2 bytes
	localparam logic [15:0] DMA_WIN_HD = 16'h860e;  // 2 bytes, ste only

	// bus_cycle slot in which dma or blitter may own the ram
	localparam logic [1:0] CPU_SLOT = 2'd1;

	// audio midpoints
	localparam logic [9:0] PSG_BIAS = 10'h200;
	localparam logic [7:0] DSND_BIAS = 8'h80;
	localparam int MIX_W = 15;

	// source of the data returned to the 68000, highest priority first
	typedef enum logic [2:0] {
		src_dma,
		src_blitter,
		src_shifter,
		src_mfp,
		src_rom,
		src_acia,
		src_snd,
		src_mcu
	} read_src_e;

	// owner of the ram port
	typedef enum logic [1:0] {
		master_cpu,
		master_dma,
		master_blitter
	} master_e;

	// 68000 bus as seen by the glue, addr is a word address
	typedef struct packed {
		logic [23:1] addr;
		logic        as_n;
		logic        uds_n;
		logic        lds_n;
		logic        rw;
	} cpu_bus_t;

	// selects coming out of the mcu
	typedef struct packed {
		logic fcs_n;
		logic rdat_n;
		logic mfpcs_n;
		logic mfpiack_n;
		logic rom_n;
		logic n6850;
		logic sndcs;
	} chip_sel_t;

	// dma or blitter bus master request
	typedef struct packed {
		logic [23:1] addr;
		logic        read;
		logic        write;
		logic [15:0] dout;
	} master_req_t;

	// request towards the sdram controller
	typedef struct packed {
		logic [23:1] addr;
		logic        oe;
		logic        we;
		logic        uds;
		logic        lds;
		logic [15:0] din;
	} ram_req_t;

	typedef struct packed {
		read_src_e read_src;
		master_e   master;
		logic      blitter_sel;
		logic      dma_sel;
	} decode_t;

endpackage

//--- hw/bus_decode.sv
// ------------------------------
// register window decode for blitter and dma,
// read source priority and ram master choice
// ------------------------------

module bus_decode (
	input  ste_glue_pkg::cpu_bus_t  cpu,
	input  ste_glue_pkg::chip_sel_t sel,
	input  logic                    ste,
	input  logic                    blitter_enable,
	input  logic                    dma_br,
	input  logic                    blitter_bgack,
	input  logic [1:0]              bus_cycle,
	output ste_glue_pkg::decode_t   dec
);

	logic page_hit;
	logic strobe;
	logic blitter_sel;
	logic dma_sel;
	logic win_a;
	logic win_b;
	logic win_hd;
	ste_glue_pkg::read_src_e read_src;
	ste_glue_pkg::master_e   master;

	assign page_hit = (cpu.addr[23:16] == ste_glue_pkg::IO_PAGE);
	assign strobe = ~cpu.as_n & ~(cpu.uds_n & cpu.lds_n);  // at least one ds active

	// ff8a00..ff8a3f, the ste always carries a blitter
	assign blitter_sel = (blitter_enable | ste) & page_hit & strobe &
		({cpu.addr[15:6], 6'd0} == ste_glue_pkg::BLITTER_BASE);

	assign win_a = ({cpu.addr[15:2], 2'd0} == ste_glue_pkg::DMA_WIN_A);
	assign win_b = ({cpu.addr[15:1], 1'b0} == ste_glue_pkg::DMA_WIN_B);
	assign win_hd = ({cpu.addr[15:1], 1'b0} == ste_glue_pkg::DMA_WIN_HD) & ste;

	// fcs_n covers the word-only ff8604 pair
	assign dma_sel = page_hit & strobe & (~sel.fcs_n | win_a | win_b | win_hd);

	always_comb begin
		if (dma_sel)
			read_src = ste_glue_pkg::src_dma;
		else if (blitter_sel)
			read_src = ste_glue_pkg::src_blitter;
		else if (!sel.rdat_n)
			read_src = ste_glue_pkg::src_shifter;
		else if (!(sel.mfpcs_n & sel.mfpiack_n))  // register access or int ack
			read_src = ste_glue_pkg::src_mfp;
		else if (!sel.rom_n)
			read_src = ste_glue_pkg::src_rom;
		else if (!sel.n6850)
			read_src = ste_glue_pkg::src_acia;
		else if (sel.sndcs)
			read_src = ste_glue_pkg::src_snd;
		else
			read_src = ste_glue_pkg::src_mcu;
	end

	// other masters only get the ram in the cpu slot
	always_comb begin
		master = ste_glue_pkg::master_cpu;
		if ((bus_cycle == ste_glue_pkg::CPU_SLOT) && (dma_br | blitter_bgack)) begin
			if (dma_br)
				master = ste_glue_pkg::master_dma;  // dma wins over blitter
			else
				master = ste_glue_pkg::master_blitter;
		end
	end

	assign dec = '{
		read_src:    read_src,
		master:      master,
		blitter_sel: blitter_sel,
		dma_sel:     dma_sel
	};

endmodule

//--- hw/ram_bus_mux.sv
// ------------------------------
// single ram port multiplexer between the cpu path
// and the dma / blitter masters, plus the ras edge strobes
// ------------------------------

module ram_bus_mux (
	input  logic                      clk_32,
	input  logic                      xsint,
	input  ste_glue_pkg::decode_t     dec,
	input  ste_glue_pkg::master_req_t dma,
	input  ste_glue_pkg::master_req_t blit,
	input  logic [23:1]               mcu_addr,
	input  logic                      ras_n,
	input  logic                      mcu_we_n,
	input  logic                      mcu_uds,
	input  logic                      mcu_lds,
	input  logic [15:0]               shifter_wdata,
	input  logic                      dma_br,
	input  logic                      blitter_bgack,
	output ste_glue_pkg::ram_req_t    ram,
	output logic                      br
);

	logic ras_n_d;
	logic ras_fall;
	logic cpu_oe;
	logic cpu_we;
	ste_glue_pkg::master_req_t bm;  // master owning the slot

	// previous ras level, idles high so no strobe after reset
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			ras_n_d <= 1'b1;
		else
			ras_n_d <= ras_n;
	end

	assign ras_fall = ras_n_d & ~ras_n;

	// reads of address zero are suppressed
	assign cpu_oe = ras_fall & mcu_we_n & (|mcu_addr);
	assign cpu_we = ras_fall & ~mcu_we_n;

	assign bm = (dec.master == ste_glue_pkg::master_dma) ? dma : blit;

	always_comb begin
		// write data follows bus ownership, not the slot
		if (dma_br)
			ram.din = dma.dout;
		else if (blitter_bgack)
			ram.din = blit.dout;
		else
			ram.din = shifter_wdata;

		if (dec.master == ste_glue_pkg::master_cpu) begin
			ram.addr = mcu_addr;
			ram.oe = cpu_oe;
			ram.we = cpu_we;
			ram.uds = mcu_uds;
			ram.lds = mcu_lds;
		end else begin
			ram.addr = bm.addr;
			ram.oe = bm.read;
			ram.we = bm.write;
			ram.uds = 1'b1;  // masters always move whole words
			ram.lds = 1'b1;
		end
	end

	// halts the cpu while another master holds the bus
	assign br = dma_br | blitter_bgack;

endmodule

//--- hw/cpu_read_mux.sv
// ------------------------------
// read data return to the 68000 and combined dtack
// ------------------------------

module cpu_read_mux (
	input  ste_glue_pkg::decode_t dec,
	input  logic [15:0]           dma_rdata,
	input  logic [15:0]           blit_rdata,
	input  logic [15:0]           shifter_rdata,
	input  logic [7:0]            mfp_rdata,
	input  logic [15:0]           rom_rdata,
	input  logic [7:0]            acia_rdata,
	input  logic [7:0]            snd_rdata,
	input  logic [15:0]           mcu_rdata,
	input  logic                  mcu_dtack_n,
	input  logic                  mfp_dtack,
	input  logic                  dma_br,
	output logic [15:0]           cpu_din,
	output logic                  dtack_n
);

	always_comb begin
		case (dec.read_src)
			ste_glue_pkg::src_dma:     cpu_din = dma_rdata;
			ste_glue_pkg::src_blitter: cpu_din = blit_rdata;
			ste_glue_pkg::src_shifter: cpu_din = shifter_rdata;
			ste_glue_pkg::src_mfp:     cpu_din = {8'hff, mfp_rdata};  // odd byte device
			ste_glue_pkg::src_rom:     cpu_din = rom_rdata;
			ste_glue_pkg::src_acia:    cpu_din = {acia_rdata, 8'hff};
			ste_glue_pkg::src_snd:     cpu_din = {snd_rdata, 8'hff};
			default:                   cpu_din = mcu_rdata;
		endcase
	end

	// internal windows acknowledge at once
	// no dtack at all while dma owns the bus
	assign dtack_n = (mcu_dtack_n & ~mfp_dtack & ~dec.dma_sel & ~dec.blitter_sel) | dma_br;

endmodule

//--- hw/audio_mix.sv
// ------------------------------
// psg mono/stereo sum mixed with ste dma sound
// into registered 15 bit left and right samples
// ------------------------------

module audio_mix (
	input  logic                           clk_32,
	input  logic                           xsint,
	input  logic [7:0]                     psg_a,
	input  logic [7:0]                     psg_b,
	input  logic [7:0]                     psg_c,
	input  logic                           psg_stereo,
	input  logic [7:0]                     dsnd_l,
	input  logic [7:0]                     dsnd_r,
	output logic [ste_glue_pkg::MIX_W-1:0] audio_l,
	output logic [ste_glue_pkg::MIX_W-1:0] audio_r
);

	logic [9:0] psg_mono;
	logic [9:0] psg_l;
	logic [9:0] psg_r;

	// remove the midpoints and stretch both to 14 bits plus sign
	function automatic logic [ste_glue_pkg::MIX_W-1:0] mix_term(
		input logic [9:0] psg,
		input logic [7:0] dsnd
	);
		logic [9:0] p;
		logic [7:0] d;
		p = psg - ste_glue_pkg::PSG_BIAS;
		d = dsnd - ste_glue_pkg::DSND_BIAS;
		return {p[9], p, p[9:6]} + {d[7], d, d[7:2]};
	endfunction

	assign psg_mono = 10'(psg_a) + 10'(psg_b) + 10'(psg_c);

	// b is the centre channel in stereo
	assign psg_l = psg_stereo ? 10'(psg_a) + 10'(psg_b) : psg_mono;
	assign psg_r = psg_stereo ? 10'(psg_c) + 10'(psg_b) : psg_mono;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= mix_term(psg_l, dsnd_l);
			audio_r <= mix_term(psg_r, dsnd_r);
		end
	end

endmodule

//--- hw/ste_glue.sv
// ------------------------------
// STE chipset glue top level, sits between the mcu,
// cpu, masters, sdram controller and audio dac
// ------------------------------

module ste_glue (
	input  logic                           clk_32,
	input  logic                           xsint,

	// cpu side
	input  ste_glue_pkg::cpu_bus_t         cpu,
	input  ste_glue_pkg::chip_sel_t        sel,
	input  logic                           ste,
	input  logic                           blitter_enable,
	output logic [15:0]                    cpu_din,
	output logic                           dtack_n,
	output logic                           br,

	// bus masters and ram timing
	input  logic                           dma_br,
	input  logic                           blitter_bgack,
	input  logic [1:0]                     bus_cycle,
	input  ste_glue_pkg::master_req_t      dma,
	input  ste_glue_pkg::master_req_t      blit,
	input  logic [23:1]                    mcu_addr,
	input  logic                           ras_n,
	input  logic                           mcu_we_n,
	input  logic                           mcu_uds,
	input  logic                           mcu_lds,
	input  logic [15:0]                    shifter_wdata,
	output ste_glue_pkg::ram_req_t         ram_req,

	// read data sources
	input  logic [15:0]                    dma_rdata,
	input  logic [15:0]                    blit_rdata,
	input  logic [15:0]                    shifter_rdata,
	input  logic [7:0]                     mfp_rdata,
	input  logic [15:0]                    rom_rdata,
	input  logic [7:0]                     acia_rdata,
	input  logic [7:0]                     snd_rdata,
	input  logic [15:0]                    mcu_rdata,
	input  logic                           mcu_dtack_n,
	input  logic                           mfp_dtack,

	// audio
	input  logic [7:0]                     psg_a,
	input  logic [7:0]                     psg_b,
	input  logic [7:0]                     psg_c,
	input  logic                           psg_stereo,
	input  logic [7:0]                     dsnd_l,
	input  logic [7:0]                     dsnd_r,
	output logic [ste_glue_pkg::MIX_W-1:0] audio_l,
	output logic [ste_glue_pkg::MIX_W-1:0] audio_r
);

	ste_glue_pkg::decode_t dec;

	bus_decode u_bus_decode (
		.cpu            (cpu),
		.sel            (sel),
		.ste            (ste),
		.blitter_enable (blitter_enable),
		.dma_br         (dma_br),
		.blitter_bgack  (blitter_bgack),
		.bus_cycle      (bus_cycle),
		.dec            (dec)
	);

	ram_bus_mux u_ram_bus_mux (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.dec            (dec),
		.dma            (dma),
		.blit           (blit),
		.mcu_addr       (mcu_addr),
		.ras_n          (ras_n),
		.mcu_we_n       (mcu_we_n),
		.mcu_uds        (mcu_uds),
		.mcu_lds        (mcu_lds),
		.shifter_wdata  (shifter_wdata),
		.dma_br         (dma_br),
		.blitter_bgack  (blitter_bgack),
		.ram            (ram_req),
		.br             (br)
	);

	cpu_read_mux u_cpu_read_mux (
		.dec            (dec),
		.dma_rdata      (dma_rdata),
		.blit_rdata     (blit_rdata),
		.shifter_rdata  (shifter_rdata),
		.mfp_rdata      (mfp_rdata),
		.rom_rdata      (rom_rdata),
		.acia_rdata     (acia_rdata),
		.snd_rdata      (snd_rdata),
		.mcu_rdata      (mcu_rdata),
		.mcu_dtack_n    (mcu_dtack_n),
		.mfp_dtack      (mfp_dtack),
		.dma_br         (dma_br),
		.cpu_din        (cpu_din),
		.dtack_n        (dtack_n)
	);

	audio_mix u_audio_mix (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.psg_a          (psg_a),
		.psg_b          (psg_b),
		.psg_c          (psg_c),
		.psg_stereo     (psg_stereo),
		.dsnd_l         (dsnd_l),
		.dsnd_r         (dsnd_r),
		.audio_l        (audio_l),
		.audio_r        (audio_r)
	);

endmodule

//--- tb/ste_glue_assert.sv
// ------------------------------
// concurrent checks on the ram port strobes and br,
// bound into every ram_bus_mux instance
// ------------------------------

module ste_glue_assert (
	input logic                   clk_32,
	input logic                   xsint,
	input ste_glue_pkg::decode_t  dec,
	input ste_glue_pkg::ram_req_t ram,
	input logic                   br,
	input logic                   dma_br,
	input logic                   blitter_bgack
);

	timeunit 1ns;
	timeprecision 1ps;

	logic cpu_strobe;
	int fail_count = 0;  // failed assertions so far

	assign cpu_strobe = (dec.master == ste_glue_pkg::master_cpu) & (ram.oe | ram.we);

	// read and write never together
	oe_we_excl: assert property (@(posedge clk_32) disable iff (!xsint)
		!(ram.oe && ram.we))
		else begin
			fail_count++;
			$error("ram oe and we both high");
		end

	// ras edge strobe lasts one cycle on the cpu path
	strobe_single: assert property (@(posedge clk_32) disable iff (!xsint)
		cpu_strobe |=> !cpu_strobe)
		else begin
			fail_count++;
			$error("cpu ram strobe longer than one cycle");
		end

	br_rule: assert property (@(posedge clk_32) disable iff (!xsint)
		br == (dma_br | blitter_bgack))
		else begin
			fail_count++;
			$error("br does not follow dma_br or blitter_bgack");
		end

endmodule

bind ram_bus_mux ste_glue_assert u_ste_glue_assert (
	.clk_32        (clk_32),
	.xsint         (xsint),
	.dec           (dec),
	.ram           (ram),
	.br            (br),
	.dma_br        (dma_br),
	.blitter_bgack (blitter_bgack)
);

//--- tb/ste_glue_tb.sv
// ------------------------------
// directed testbench for the STE glue top level
// inputs change on the falling edge, checks 5 ns later
// ------------------------------

module ste_glue_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// reset, decode, priority, arbitration, ras, dtack, audio
	localparam int TEST_CYCLES = 10 + 15 + 24 + 7 + 10 + 25 + 24;

	logic clk_32;
	logic xsint;
	ste_glue_pkg::cpu_bus_t cpu;
	ste_glue_pkg::chip_sel_t sel;
	logic ste;
	logic blitter_enable;
	logic dma_br;
	logic blitter_bgack;
	logic [1:0] bus_cycle;
	ste_glue_pkg::master_req_t dma;
	ste_glue_pkg::master_req_t blit;
	logic [23:1] mcu_addr;
	logic ras_n;
	logic mcu_we_n;
	logic mcu_uds;
	logic mcu_lds;
	logic [15:0] shifter_wdata;
	ste_glue_pkg::ram_req_t ram_req;
	logic [15:0] dma_rdata;
	logic [15:0] blit_rdata;
	logic [15:0] shifter_rdata;
	logic [15:0] rom_rdata;
	logic [15:0] mcu_rdata;
	logic [7:0] mfp_rdata;
	logic [7:0] acia_rdata;
	logic [7:0] snd_rdata;
	logic mcu_dtack_n;
	logic mfp_dtack;
	logic [15:0] cpu_din;
	logic dtack_n;
	logic br;
	logic [7:0] psg_a;
	logic [7:0] psg_b;
	logic [7:0] psg_c;
	logic [7:0] dsnd_l;
	logic [7:0] dsnd_r;
	logic psg_stereo;
	logic [14:0] audio_l;
	logic [14:0] audio_r;

	ste_glue UUT (.*);

	initial begin
		clk_32 = 1'b0;
		forever #10 clk_32 = ~clk_32;
	end

	initial begin
		#(TEST_CYCLES * 20 + 1000);
		$display("timeout, the tests did not finish in time");
		$display("Simulation FAILED");
		$fatal(1);
	end

	// bound ram port checker
	initial begin
		wait (UUT.u_ram_bus_mux.u_ste_glue_assert.fail_count != 0);
		$display("an assertion on the ram port failed");
		$display("Simulation FAILED");
		$fatal(1);
	end

	task automatic compare_value(input string name, input logic [31:0] exp, act);
		if (exp !== act) begin
			$display("Mismatch %s expected %h actual %h", name, exp, act);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	// byte address onto the cpu bus, upper strobe only
	task automatic cpu_access(input logic [23:0] a, input logic as_n);
		cpu = '{addr: a[23:1], as_n: as_n, uds_n: 1'b0, lds_n: 1'b1, rw: 1'b1};
	endtask

	task automatic idle_selects();
		sel = '{fcs_n: 1'b1, rdat_n: 1'b1, mfpcs_n: 1'b1, mfpiack_n: 1'b1,
			rom_n: 1'b1, n6850: 1'b1, sndcs: 1'b0};
	endtask

	task automatic decode_case(input string name, input logic [23:0] a,
		input logic ste_on, input logic blit_on, input logic [15:0] exp);
		@(negedge clk_32);
		ste = ste_on;
		blitter_enable = blit_on;
		cpu_access(a, 1'b0);
		#5;
		compare_value(name, exp, cpu_din);
	endtask

	task automatic test_decode();
		idle_selects();
		decode_case("blit_lo", 24'hff8a00, 0, 1, 16'h2222);
		decode_case("blit_hi", 24'hff8a3e, 0, 1, 16'h2222);
		decode_case("blit_above", 24'hff8a40, 0, 1, 16'h8888);
		decode_case("blit_below", 24'hff89fe, 0, 1, 16'h8888);
		decode_case("blit_off", 24'hff8a00, 0, 0, 16'h8888);
		decode_case("blit_ste", 24'hff8a10, 1, 0, 16'h2222);
		decode_case("dma_a0", 24'hff8608, 0, 1, 16'h1111);
		decode_case("dma_a1", 24'hff860a, 0, 1, 16'h1111);
		decode_case("dma_below", 24'hff8606, 0, 1, 16'h8888);
		decode_case("dma_b", 24'hff860c, 0, 1, 16'h1111);
		decode_case("dma_hd_st", 24'hff860e, 0, 1, 16'h8888);
		decode_case("dma_hd_ste", 24'hff860e, 1, 1, 16'h1111);
		decode_case("dma_above", 24'hff8610, 1, 1, 16'h8888);
		decode_case("dma_page", 24'hfe8608, 1, 1, 16'h8888);
		@(negedge clk_32);
		cpu_access(24'hff8608, 1'b1);  // no address strobe
		#5;
		compare_value("dma_no_as", 16'h8888, cpu_din);
	endtask

	function automatic logic [15:0] expected_read(input ste_glue_pkg::chip_sel_t s);
		if (!s.fcs_n) return dma_rdata;
		if (!s.rdat_n) return shifter_rdata;
		if (!s.mfpcs_n || !s.mfpiack_n) return {8'hff, mfp_rdata};
		if (!s.rom_n) return rom_rdata;
		if (!s.n6850) return {acia_rdata, 8'hff};
		if (s.sndcs) return {snd_rdata, 8'hff};
		return mcu_rdata;
	endfunction

	task automatic test_read_priority();
		for (int i = 0; i < 24; i++) begin
			@(negedge clk_32);
			cpu_access(24'hff8800, 1'b0);  // io page, outside both windows
			sel = 7'($urandom);
			#5;
			compare_value("read_priority", expected_read(sel), cpu_din);
		end
		idle_selects();
	endtask

	task automatic test_arbitration();
		logic [1:0] slot;
		logic use_dma;
		logic use_blit;
		logic own_dma;
		logic own_blit;
		dma = '{addr: 23'h111111, read: 1'b1, write: 1'b0, dout: 16'ha1a1};
		blit = '{addr: 23'h222222, read: 1'b0, write: 1'b1, dout: 16'hb2b2};
		for (int s = 0; s < 2; s++) begin
			for (int c = 1; c < 4; c++) begin
				slot = (s == 0) ? ste_glue_pkg::CPU_SLOT : 2'd2;
				use_dma = c[0];
				use_blit = c[1];
				own_dma = (slot == ste_glue_pkg::CPU_SLOT) && use_dma;
				own_blit = (slot == ste_glue_pkg::CPU_SLOT) && !use_dma;
				@(negedge clk_32);
				bus_cycle = slot;
				dma_br = use_dma;
				blitter_bgack = use_blit;
				#5;
				compare_value("arb_addr", own_dma ? dma.addr :
					(own_blit ? blit.addr : mcu_addr), ram_req.addr);
				compare_value("arb_oe", own_dma, ram_req.oe);
				compare_value("arb_we", own_blit, ram_req.we);
				compare_value("arb_uds", (own_dma | own_blit) | mcu_uds, ram_req.uds);
				compare_value("arb_lds", (own_dma | own_blit) | mcu_lds, ram_req.lds);
				compare_value("arb_din", use_dma ? dma.dout : blit.dout, ram_req.din);
				compare_value("arb_br", 1'b1, br);
			end
		end
		@(negedge clk_32);
		dma_br = 1'b0;
		blitter_bgack = 1'b0;
		#5;
		compare_value("arb_din_cpu", shifter_wdata, ram_req.din);
	endtask

	// one falling ras edge, strobe checked on that cycle and the next
	task automatic ras_cycle(input string name, input logic [23:1] a,
		input logic we_n, input logic exp_oe, input logic exp_we);
		@(negedge clk_32);
		ras_n = 1'b1;
		mcu_addr = a;
		mcu_we_n = we_n;
		@(negedge clk_32);
		ras_n = 1'b0;
		#5;
		compare_value({name, "_oe"}, exp_oe, ram_req.oe);
		compare_value({name, "_we"}, exp_we, ram_req.we);
		@(negedge clk_32);
		#5;
		compare_value({name, "_oe_end"}, 1'b0, ram_req.oe);
		compare_value({name, "_we_end"}, 1'b0, ram_req.we);
	endtask

	task automatic test_ras_strobe();
		ras_cycle("ras_read", 23'h000123, 1'b1, 1'b1, 1'b0);
		ras_cycle("ras_write", 23'h000456, 1'b0, 1'b0, 1'b1);
		ras_cycle("ras_zero", 23'h000000, 1'b1, 1'b0, 1'b0);
		@(negedge clk_32);
		ras_n = 1'b1;
		mcu_addr = 23'h000123;
	endtask

	task automatic test_dtack();
		logic [23:0] a;
		logic hit;
		for (int w = 0; w < 3; w++) begin
			for (int i = 0; i < 8; i++) begin
				a = (w == 0) ? 24'hff8800 : ((w == 1) ? 24'hff8608 : 24'hff8a00);
				hit = (w != 0);
				@(negedge clk_32);
				cpu_access(a, 1'b0);
				mcu_dtack_n = i[0];
				mfp_dtack = i[1];
				dma_br = i[2];
				#5;
				compare_value("dtack", (mcu_dtack_n & !mfp_dtack & !hit) | dma_br, dtack_n);
			end
		end
		@(negedge clk_32);
		dma_br = 1'b0;
		mcu_dtack_n = 1'b1;
		mfp_dtack = 1'b0;
	endtask

	// bias removed, then sign and top bits stretch each term to 15 bits
	function automatic logic [14:0] expected_mix(input logic [9:0] psg, input logic [7:0] ds);
		logic [9:0] p;
		logic [7:0] d;
		logic [14:0] pt;
		logic [14:0] dt;
		p = psg - 10'h200;
		d = ds - 8'h80;
		pt = {p[9], p, p[9:6]};
		dt = {d[7], d, d[7:2]};
		return pt + dt;
	endfunction

	task automatic test_audio();
		logic [9:0] sum_l;
		logic [9:0] sum_r;
		logic [14:0] exp_l;
		logic [14:0] exp_r;
		for (int i = 0; i < 24; i++) begin
			@(negedge clk_32);
			psg_a = 8'($urandom);
			psg_b = 8'($urandom);
			psg_c = 8'($urandom);
			dsnd_l = 8'($urandom);
			dsnd_r = 8'($urandom);
			psg_stereo = i[0];
			sum_l = psg_stereo ? psg_a + psg_b : psg_a + psg_b + psg_c;
			sum_r = psg_stereo ? psg_c + psg_b : psg_a + psg_b + psg_c;
			exp_l = expected_mix(sum_l, dsnd_l);
			exp_r = expected_mix(sum_r, dsnd_r);
			@(posedge clk_32);
			#5;
			compare_value("audio_l", exp_l, audio_l);
			compare_value("audio_r", exp_r, audio_r);
		end
	endtask

	initial begin
		void'($urandom(32'h7e7a49e9));
		xsint = 1'b0;
		cpu_access(24'h001000, 1'b1);
		idle_selects();
		ste = 1'b0;
		blitter_enable = 1'b1;
		dma_br = 1'b0;
		blitter_bgack = 1'b0;
		bus_cycle = 2'd0;
		dma = '0;
		blit = '0;
		mcu_addr = 23'h000123;
		ras_n = 1'b1;
		mcu_we_n = 1'b1;
		mcu_uds = 1'b0;
		mcu_lds = 1'b1;
		shifter_wdata = 16'hc3c3;
		// distinct value per read source
		dma_rdata = 16'h1111;
		blit_rdata = 16'h2222;
		shifter_rdata = 16'h3333;
		mfp_rdata = 8'h44;
		rom_rdata = 16'h5555;
		acia_rdata = 8'h66;
		snd_rdata = 8'h77;
		mcu_rdata = 16'h8888;
		mcu_dtack_n = 1'b1;
		mfp_dtack = 1'b0;
		psg_a = '0;
		psg_b = '0;
		psg_c = '0;
		dsnd_l = '0;
		dsnd_r = '0;
		psg_stereo = 1'b0;
		repeat (10) @(negedge clk_32);
		xsint = 1'b1;
		#5;
		compare_value("audio_l_reset", 15'd0, audio_l);
		compare_value("audio_r_reset", 15'd0, audio_r);
		compare_value("oe_reset", 1'b0, ram_req.oe);
		test_decode();
		test_read_priority();
		test_arbitration();
		test_ras_strobe();
		test_dtack();
		test_audio();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- ste_glue.f
hw/ste_glue_pkg.sv
hw/bus_decode.sv
hw/ram_bus_mux.sv
hw/cpu_read_mux.sv
hw/audio_mix.sv
hw/ste_glue.sv
tb/ste_glue_assert.sv
tb/ste_glue_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it, pass is found in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module ste_glue_tb \
	-f ste_glue.f -o ste_glue_sim &&
./obj_dir/ste_glue_sim | tee /dev/stderr | grep "Simulation PASSED" > /dev/null &&
echo "run ok" ||
{ echo "run failed"; exit 1; }
